/* Bender.yml */
package:
  name: ttc_trigger_path

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/trig_types_pkg.sv
      - hdl/trig_fsm_pkg.sv
      - hdl/sync_fifo.sv
      - hdl/ttc_trigger_receiver.sv
      - hdl/channel_acq_controller.sv
      - hdl/trigger_processor.sv
      - hdl/trigger_top.sv
  - target: simulation
    files:
      - dv/trigger_checker.sv
      - dv/trigger_tb.sv

/* dv/trigger_checker.sv */
// concurrent assertions on the trigger top-level ports, bound to trigger_top
`timescale 1ns/100ps
`default_nettype none

module trigger_checker
    import trig_types_pkg::*;
(
    input wire            ttc_clk,
    input wire            rst_n,
    input wire chan_mask_t chan_trig,
    input wire            initiate_readout,
    input wire            send_empty_event,
    input wire            error_trig_num,
    input wire            error_trig_type,
    input wire trig_num_t trig_num
);

    int fail_cnt = 0;  // assertion failures so far

    // ------------------------------------------------------------
    // handshake shape
    // ------------------------------------------------------------
    a_chan_trig_pulse: assert property (@(posedge ttc_clk) disable iff (!rst_n)
        (chan_trig != '0) |=> (chan_trig == '0))
        else begin
            fail_cnt++;
            $error("chan_trig high two cycles in a row");
        end

    a_req_exclusive: assert property (@(posedge ttc_clk) disable iff (!rst_n)
        !(initiate_readout && send_empty_event))
        else begin
            fail_cnt++;
            $error("readout and empty event requested together");
        end

    // ------------------------------------------------------------
    // FIFO pairing stays consistent
    // ------------------------------------------------------------
    a_no_num_err: assert property (@(posedge ttc_clk) disable iff (!rst_n) !error_trig_num)
        else begin
            fail_cnt++;
            $error("error_trig_num set");
        end

    a_no_type_err: assert property (@(posedge ttc_clk) disable iff (!rst_n) !error_trig_type)
        else begin
            fail_cnt++;
            $error("error_trig_type set");
        end

    // numbering steps by one or restarts at 1
    a_trig_num_step: assert property (@(posedge ttc_clk) disable iff (!rst_n)
        (trig_num != $past(trig_num)) |->
            (trig_num == trig_num_t'($past(trig_num) + 1'b1) || trig_num == trig_num_t'(1)))
        else begin
            fail_cnt++;
            $error("trig_num jumped");
        end

endmodule

bind trigger_top trigger_checker port_checks (
    .ttc_clk(ttc_clk), .rst_n(rst_n), .chan_trig(chan_trig),
    .initiate_readout(initiate_readout), .send_empty_event(send_empty_event),
    .error_trig_num(error_trig_num), .error_trig_type(error_trig_type),
    .trig_num(trig_num)
);

`default_nettype wire

/* dv/trigger_tb.sv */
// testbench: clock, reset, random stimulus, channel and command manager models, reference model
`timescale 1ns/100ps
`default_nettype none

module trigger_tb
    import trig_types_pkg::*, trig_fsm_pkg::*;
();

    localparam int NUM_TRIGS   = 300;
    localparam int WATCHDOG_NS = NUM_TRIGS * 400 * 4;  // 400 cycles of 4 ns per trigger
    localparam int SEED        = 58154;

    typedef struct packed {
        readout_info_t info;
        logic          empty;  // expect send_empty_event
    } exp_evt_t;

    logic          ttc_clk = 1'b0;
    logic          rst_n, ttc_trigger, rst_trigger_num, rst_trigger_timestamp;
    logic          readout_ready, readout_done;
    trig_type_t    trig_type;
    chan_mask_t    chan_en, chan_dones, chan_trig;
    delay_t        trig_delay;
    logic          initiate_readout, send_empty_event, trig_fifo_full, acq_fifo_full;
    logic          error_trig_rate, error_trig_num, error_trig_type;
    readout_info_t ttc_info;
    trig_num_t     trig_num;
    timestamp_t    trig_timestamp;
    acq_state_t    cac_state;
    tp_state_t     tp_state;

    // reference model state
    exp_evt_t   exp_q [$];
    exp_evt_t   got_evt, new_evt;
    logic       acc, acc_q, num_pend, rate_err;
    trig_num_t  num_ref, evt_ref;
    timestamp_t ts_ref;
    timestamp_t ts_acc;  // timestamp of the latest accepted trigger
    longint     cyc, fire_cyc;
    chan_mask_t fire_mask;
    int         done_cnt [$bits(chan_mask_t)];  // per channel, cycles to done
    int         done_wait, ready_hold;

    trigger_top UUT (.*);

    always #2 ttc_clk = ~ttc_clk;

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------
    task automatic report_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_info(input readout_info_t got, input readout_info_t exp);
        if (got !== exp)
            report_error($sformatf(
                "ttc_info evt %0d num %0d type %0d ts %0d, expected %0d %0d %0d %0d",
                got.event_num, got.trig_num, got.trig_type, got.timestamp,
                exp.event_num, exp.trig_num, exp.trig_type, exp.timestamp));
    endtask

    task automatic check_mask(input chan_mask_t got, input chan_mask_t exp);
        if (got !== exp)
            report_error($sformatf("chan_trig %b, expected %b", got, exp));
    endtask

    task automatic check_num(input trig_num_t got, input trig_num_t exp);
        if (got !== exp)
            report_error($sformatf("trig_num %0d, expected %0d", got, exp));
    endtask

    task automatic check_ts(input timestamp_t got, input timestamp_t exp);
        if (got !== exp)
            report_error($sformatf("trig_timestamp %0d, expected %0d", got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    // ------------------------------------------------------------
    // reference model, sampled values before the edge
    // ------------------------------------------------------------
    always @(posedge ttc_clk) begin
        if (!rst_n) begin
            {acc_q, num_pend, rate_err} = '0;
            num_ref   = '0;
            evt_ref   = '0;
            ts_ref    = '0;
            ts_acc    = '0;
            cyc       = 0;
            fire_cyc  = -1;
            fire_mask = '0;
            // reset values of the outputs
            check_mask(chan_trig, chan_mask_t'(0));
            check_flag(initiate_readout, 1'b0, "initiate_readout in reset");
            check_flag(send_empty_event, 1'b0, "send_empty_event in reset");
            check_flag(error_trig_rate, 1'b0, "error_trig_rate in reset");
            check_num(trig_num, trig_num_t'(0));
            check_flag(cac_state == ACQ_IDLE, 1'b1, "cac_state idle in reset");
            check_flag(tp_state == TP_IDLE, 1'b1, "tp_state idle in reset");
        end else begin
            // busy controller, request in flight or FIFO near full refuse it
            acc = ttc_trigger && (cac_state == ACQ_IDLE) && !trig_fifo_full && !acc_q;
            check_flag(error_trig_rate, rate_err, "error_trig_rate");
            check_flag(error_trig_num, 1'b0, "error_trig_num");
            check_flag(error_trig_type, 1'b0, "error_trig_type");
            check_num(trig_num, num_ref);
            check_ts(trig_timestamp, ts_acc);
            // acquisition FIFO never holds more than the trigger FIFO
            if (acq_fifo_full)
                check_flag(trig_fifo_full, 1'b1, "trig_fifo_full with acq_fifo_full");
            check_mask(chan_trig, (cyc == fire_cyc) ? fire_mask : chan_mask_t'(0));
            if (initiate_readout || send_empty_event) begin
                if (exp_q.size() == 0)
                    report_error("readout request with no accepted trigger left");
                got_evt = exp_q.pop_front();
                check_info(ttc_info, got_evt.info);
                check_flag(send_empty_event, got_evt.empty, "send_empty_event");
            end
            if (ttc_trigger && !acc)
                rate_err = 1'b1;                  // sticky
            if (acc) begin
                num_ref = (num_pend || rst_trigger_num) ? trig_num_t'(1) : num_ref + 1'b1;
                evt_ref = evt_ref + 1'b1;
                ts_acc  = ts_ref;
                new_evt.info.event_num = evt_ref;
                new_evt.info.trig_num  = num_ref;
                new_evt.info.trig_type = trig_type;
                new_evt.info.timestamp = ts_ref;  // count at the accepting edge
                new_evt.empty          = (chan_en == '0);
                exp_q.push_back(new_evt);
                if (chan_en != '0) begin
                    fire_cyc  = cyc + trig_delay + 3;  // high from edge +d+2, seen one later
                    fire_mask = chan_en;
                end
                num_pend = 1'b0;
            end else if (rst_trigger_num) begin
                num_pend = 1'b1;
            end
            ts_ref = rst_trigger_timestamp ? timestamp_t'(0) : ts_ref + 1'b1;
            acc_q  = acc;
            cyc++;
        end
    end

    // channels, done bits rise 1..20 cycles after the pulse
    always @(posedge ttc_clk) begin
        if (chan_trig != '0) begin
            chan_dones <= '0;
            for (int i = 0; i < $bits(chan_mask_t); i++)
                done_cnt[i] = chan_trig[i] ? 1 + $urandom % 20 : 0;
        end else begin
            for (int i = 0; i < $bits(chan_mask_t); i++) begin
                if (done_cnt[i] != 0) begin
                    if (done_cnt[i] == 1)
                        chan_dones[i] <= 1'b1;
                    done_cnt[i]--;
                end
            end
        end
    end

    // command manager, random ready stretches and late done pulses
    always @(posedge ttc_clk) begin
        readout_done <= 1'b0;
        if (initiate_readout || send_empty_event) begin
            done_wait = 1 + $urandom % 15;
        end else if (done_wait != 0) begin
            if (done_wait == 1)
                readout_done <= 1'b1;
            done_wait--;
        end
        if (ready_hold != 0) begin
            ready_hold--;
        end else begin
            case ($urandom % 8)
                0: begin
                    readout_ready <= 1'b0;
                    ready_hold = 100 + $urandom % 200;
                end
                1, 2: begin
                    readout_ready <= 1'b0;
                    ready_hold = 1 + $urandom % 10;
                end
                default: begin
                    readout_ready <= 1'b1;
                    ready_hold = 5 + $urandom % 60;
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    initial begin
        int gap;
        void'($urandom(SEED));
        rst_n                 = 1'b0;
        ttc_trigger           = 1'b0;
        trig_type             = '0;
        chan_en               = '0;
        trig_delay            = '0;
        rst_trigger_num       = 1'b0;
        rst_trigger_timestamp = 1'b0;
        chan_dones            = '0;
        readout_ready         = 1'b0;
        readout_done          = 1'b0;
        done_wait             = 0;
        ready_hold            = 0;
        repeat (3) @(posedge ttc_clk);
        rst_n <= 1'b1;
        for (int n = 0; n < NUM_TRIGS; n++) begin
            @(posedge ttc_clk);
            ttc_trigger           <= 1'b1;
            trig_type             <= trig_type_t'($urandom);
            chan_en               <= ($urandom % 5 == 0) ? '0 : chan_mask_t'($urandom);
            trig_delay            <= ($urandom % 10 == 0) ? delay_t'($urandom)
                                                          : delay_t'($urandom % 40);
            rst_trigger_num       <= ($urandom % 16 == 0);
            rst_trigger_timestamp <= ($urandom % 16 == 0);
            @(posedge ttc_clk);
            ttc_trigger           <= 1'b0;
            rst_trigger_num       <= 1'b0;
            rst_trigger_timestamp <= 1'b0;
            gap = ($urandom % 4 == 0) ? $urandom % 4 : 20 + $urandom % 80;  // bursts hit busy
            repeat (gap) @(posedge ttc_clk);
        end
        while (exp_q.size() != 0)
            @(posedge ttc_clk);
        repeat (20) @(posedge ttc_clk);
        if (exp_q.size() != 0 || UUT.port_checks.fail_cnt != 0) begin
            $display("%0d events never requested, %0d assertion failures",
                exp_q.size(), UUT.port_checks.fail_cnt);
            $display("SOME TESTS FAILED");
            $fatal(1, "run ended with failures");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* hdl/channel_acq_controller.sv */
// channel acquisition controller with trigger delay, channel pulse, done collection, event store
`timescale 1ns/100ps
`default_nettype none

module channel_acq_controller
    import trig_types_pkg::*, trig_fsm_pkg::*;
(
    input  wire        ttc_clk,
    input  wire        rst_n,
    input  wire        trigger,              // request from the receiver
    input  wire acq_rec_t   trig_rec,
    input  wire chan_mask_t chan_en,         // channels to trigger
    input  wire delay_t     trig_delay,
    input  wire chan_mask_t acq_dones,       // done levels from the channels
    input  wire        fifo_ready,           // acquisition FIFO not full
    output logic       acq_ready,            // high only in idle
    output chan_mask_t acq_trig,             // one-cycle channel trigger
    output logic       fifo_valid,
    output acq_rec_t   fifo_data,
    output acq_state_t state
);

    delay_t     delay_cnt;  // remaining delay cycles
    chan_mask_t mask_q;     // enabled channels of this event
    acq_rec_t   rec_q;      // event being acquired
    logic       all_done;

    assign acq_ready  = (state == ACQ_IDLE);
    assign acq_trig   = (state == ACQ_FIRE) ? mask_q : '0;
    assign fifo_valid = (state == ACQ_STORE);
    assign fifo_data  = rec_q;

    // only enabled channels count
    assign all_done = ((acq_dones & mask_q) == mask_q);

    // ------------------------------------------------------------
    // state machine
    // ------------------------------------------------------------
    always_ff @(posedge ttc_clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ACQ_IDLE;
            delay_cnt <= '0;
        end else begin
            case (state)
                ACQ_IDLE: begin
                    if (trigger) begin
                        delay_cnt <= trig_delay;
                        state     <= trig_rec.empty ? ACQ_STORE : ACQ_DELAY;
                    end
                end
                ACQ_DELAY: begin
                    if (delay_cnt == '0)
                        state <= ACQ_FIRE;
                    else
                        delay_cnt <= delay_cnt - 1'b1;
                end
                ACQ_FIRE:      state <= ACQ_WAIT_DONE;  // pulse lasts one cycle
                ACQ_WAIT_DONE: begin
                    if (all_done)
                        state <= ACQ_STORE;
                end
                ACQ_STORE: begin
                    if (fifo_ready)
                        state <= ACQ_IDLE;              // event written
                end
                default:       state <= ACQ_IDLE;
            endcase
        end
    end

    // event payload, latched with the request
    always_ff @(posedge ttc_clk) begin
        if (acq_ready && trigger) begin
            rec_q  <= trig_rec;
            mask_q <= chan_en;
        end
    end

endmodule

`default_nettype wire

/* hdl/sync_fifo.sv */
// single-clock FIFO with valid/ready ports, type parameter and almost-full flag
`timescale 1ns/100ps
`default_nettype none

`include "trigger_config.svh"

module sync_fifo #(
    parameter type ENTRY_T = logic
) (
    input  wire    ttc_clk,
    input  wire    rst_n,
    input  wire    wr_valid,
    input  wire ENTRY_T wr_data,
    output logic   wr_ready,     // not full
    output logic   rd_valid,     // not empty
    output ENTRY_T rd_data,
    input  wire    rd_ready,
    output logic   almost_full   // occupancy at or above the threshold
);

    localparam int DEPTH = `FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    ENTRY_T        mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;        // one extra bit for full
    logic          do_wr;
    logic          do_rd;

    assign wr_ready    = (count != (AW+1)'(DEPTH));
    assign rd_valid    = (count != '0);
    assign rd_data     = mem[rd_ptr];  // readable the cycle after the write
    assign almost_full = (count >= (AW+1)'(`FIFO_AFULL));
    assign do_wr       = wr_valid && wr_ready;
    assign do_rd       = rd_valid && rd_ready;

    always_ff @(posedge ttc_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
        end
    end

    // storage
    always_ff @(posedge ttc_clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

endmodule

`default_nettype wire

/* hdl/trig_fsm_pkg.sv */
// state encodings of the acquisition controller and trigger processor FSMs
`default_nettype none

package trig_fsm_pkg;

    // channel acquisition controller, exported as cac_state
    typedef enum logic [3:0] {
        ACQ_IDLE      = 4'd0,  // ready for a trigger
        ACQ_DELAY     = 4'd1,  // counting down trig_delay
        ACQ_FIRE      = 4'd2,  // channel trigger pulse
        ACQ_WAIT_DONE = 4'd3,  // waiting on enabled chan_dones
        ACQ_STORE     = 4'd4   // writing the acquisition event
    } acq_state_t;

    // trigger processor, exported as tp_state
    typedef enum logic [3:0] {
        TP_IDLE      = 4'd0,  // waiting for both FIFOs
        TP_POP       = 4'd1,  // read one entry from each
        TP_CHECK     = 4'd2,  // cross-check, build readout info
        TP_ISSUE     = 4'd3,  // request readout or empty event
        TP_WAIT_DONE = 4'd4   // waiting on readout_done
    } tp_state_t;

endpackage

`default_nettype wire

/* hdl/trig_types_pkg.sv */
// vector typedefs and packed trigger, acquisition and readout records
`default_nettype none

package trig_types_pkg;

`include "trigger_config.svh"

    // ------------------------------------------------------------
    // scalar fields
    // ------------------------------------------------------------
    typedef logic [`TRIG_NUM_W-1:0]   trig_num_t;   // trigger or event number
    typedef logic [`TIMESTAMP_W-1:0]  timestamp_t;  // free-running cycle count
    typedef logic [`TRIG_TYPE_W-1:0]  trig_type_t;
    typedef logic [`NUM_CHAN-1:0]     chan_mask_t;  // one bit per channel
    typedef logic [`TRIG_DELAY_W-1:0] delay_t;      // delay in ttc_clk cycles

    // trigger FIFO entry, 71 bits
    typedef struct packed {
        timestamp_t timestamp;  // counter value at the accepting edge
        trig_num_t  trig_num;
        trig_type_t trig_type;
    } trig_rec_t;

    // acquisition FIFO entry, 28 bits
    typedef struct packed {
        trig_num_t  trig_num;
        trig_type_t trig_type;
        logic       empty;      // no channel was enabled
    } acq_rec_t;

    // readout info to the command manager, 95 bits
    typedef struct packed {
        trig_num_t  event_num;  // counts readout requests from 1
        trig_num_t  trig_num;
        trig_type_t trig_type;
        timestamp_t timestamp;
    } readout_info_t;

endpackage

`default_nettype wire

/* hdl/trigger_config.svh */
// widths, channel count and FIFO sizing for the TTC trigger path
`ifndef TRIGGER_CONFIG_SVH
`define TRIGGER_CONFIG_SVH

// ------------------------------------------------------------
// data widths
// ------------------------------------------------------------
`define TRIG_NUM_W   24  // trigger and event number
`define TIMESTAMP_W  44  // cycles since reset or timestamp reset
`define TRIG_TYPE_W  3   // muon fill, laser, pedestal, ...
`define NUM_CHAN     5   // digitizer channels
`define TRIG_DELAY_W 8   // trigger delay count

// ------------------------------------------------------------
// FIFO sizing, shared by both FIFOs
// ------------------------------------------------------------
`define FIFO_DEPTH 8  // entries, power of two
`define FIFO_AFULL 6  // occupancy at which almost_full rises

`endif

/* hdl/trigger_processor.sv */
// trigger processor with FIFO pairing, consistency check and readout request sequencing
`timescale 1ns/100ps
`default_nettype none

module trigger_processor
    import trig_types_pkg::*, trig_fsm_pkg::*;
(
    input  wire          ttc_clk,
    input  wire          rst_n,
    input  wire          trig_valid,
    input  wire trig_rec_t trig_data,
    output logic         trig_ready,
    input  wire          acq_valid,
    input  wire acq_rec_t  acq_data,
    output logic         acq_ready,
    input  wire          readout_ready,     // command manager idle
    input  wire          readout_done,      // readout finished
    output logic         initiate_readout,
    output logic         send_empty_event,
    output readout_info_t ttc_info,         // stable until readout_done
    output tp_state_t    state,
    output logic         error_trig_num,    // sticky, number mismatch
    output logic         error_trig_type    // sticky, type mismatch
);

    trig_rec_t trig_q;
    acq_rec_t  acq_q;
    trig_num_t event_cnt;

    // both FIFOs pop together
    assign trig_ready = (state == TP_POP);
    assign acq_ready  = (state == TP_POP);

    assign initiate_readout = (state == TP_ISSUE) && readout_ready && !acq_q.empty;
    assign send_empty_event = (state == TP_ISSUE) && readout_ready && acq_q.empty;

    always_ff @(posedge ttc_clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= TP_IDLE;
            event_cnt       <= '0;
            ttc_info        <= '0;
            error_trig_num  <= 1'b0;
            error_trig_type <= 1'b0;
        end else begin
            case (state)
                TP_IDLE:  if (trig_valid && acq_valid) state <= TP_POP;
                TP_POP:   state <= TP_CHECK;
                TP_CHECK: begin
                    if (trig_q.trig_num != acq_q.trig_num)
                        error_trig_num <= 1'b1;
                    if (trig_q.trig_type != acq_q.trig_type)
                        error_trig_type <= 1'b1;
                    event_cnt          <= event_cnt + 1'b1;
                    ttc_info.event_num <= event_cnt + 1'b1;
                    ttc_info.trig_num  <= trig_q.trig_num;
                    ttc_info.trig_type <= trig_q.trig_type;
                    ttc_info.timestamp <= trig_q.timestamp;
                    state              <= TP_ISSUE;
                end
                TP_ISSUE:     if (readout_ready) state <= TP_WAIT_DONE;  // request pulsed
                TP_WAIT_DONE: if (readout_done) state <= TP_IDLE;
                default:      state <= TP_IDLE;
            endcase
        end
    end

    // popped pair
    always_ff @(posedge ttc_clk) begin
        if (state == TP_POP) begin
            trig_q <= trig_data;
            acq_q  <= acq_data;
        end
    end

endmodule

`default_nettype wire

/* hdl/trigger_top.sv */
// trigger path top level with receiver, acquisition controller, two FIFOs and processor
`timescale 1ns/100ps
`default_nettype none

module trigger_top
    import trig_types_pkg::*, trig_fsm_pkg::*;
(
    input  wire           ttc_clk,                // TTC clock
    input  wire           rst_n,
    input  wire           ttc_trigger,            // TTC trigger pulse
    input  wire trig_type_t trig_type,
    input  wire chan_mask_t chan_en,              // enabled channels
    input  wire delay_t   trig_delay,
    input  wire           rst_trigger_num,        // TTC channel B
    input  wire           rst_trigger_timestamp,  // TTC channel B
    input  wire chan_mask_t chan_dones,
    input  wire           readout_ready,          // command manager idle
    input  wire           readout_done,
    output chan_mask_t    chan_trig,
    output logic          initiate_readout,
    output logic          send_empty_event,
    output readout_info_t ttc_info,
    output trig_num_t     trig_num,
    output timestamp_t    trig_timestamp,
    output acq_state_t    cac_state,
    output tp_state_t     tp_state,
    output logic          trig_fifo_full,         // trigger FIFO almost full
    output logic          acq_fifo_full,          // acquisition FIFO almost full
    output logic          error_trig_rate,
    output logic          error_trig_num,
    output logic          error_trig_type
);

    // ------------------------------------------------------------
    // receiver to controller
    // ------------------------------------------------------------
    logic       acq_ready;
    logic       acq_trigger;
    acq_rec_t   acq_req;
    chan_mask_t acq_chan_en;
    delay_t     acq_delay;

    // ------------------------------------------------------------
    // FIFO streams
    // ------------------------------------------------------------
    logic      trig_wr_valid, trig_wr_ready, trig_room;
    trig_rec_t trig_wr_data;
    logic      trig_rd_valid, trig_rd_ready;
    trig_rec_t trig_rd_data;
    logic      acq_wr_valid, acq_wr_ready;
    acq_rec_t  acq_wr_data;
    logic      acq_rd_valid, acq_rd_ready;
    acq_rec_t  acq_rd_data;

    // receiver refuses triggers from almost full on
    assign trig_room = trig_wr_ready && !trig_fifo_full;

    ttc_trigger_receiver ttc_trigger_receiver (
        .ttc_clk(ttc_clk), .rst_n(rst_n),
        .trigger(ttc_trigger), .trig_type(trig_type),
        .chan_en(chan_en), .trig_delay(trig_delay),
        .reset_trig_num(rst_trigger_num), .reset_trig_timestamp(rst_trigger_timestamp),
        .acq_ready(acq_ready), .fifo_ready(trig_room),
        .acq_trigger(acq_trigger), .acq_rec(acq_req),
        .acq_chan_en(acq_chan_en), .acq_delay(acq_delay),
        .fifo_valid(trig_wr_valid), .fifo_data(trig_wr_data),
        .trig_num(trig_num), .trig_timestamp(trig_timestamp),
        .error_trig_rate(error_trig_rate)
    );

    channel_acq_controller channel_acq_controller (
        .ttc_clk(ttc_clk), .rst_n(rst_n),
        .trigger(acq_trigger), .trig_rec(acq_req),
        .chan_en(acq_chan_en), .trig_delay(acq_delay),
        .acq_dones(chan_dones), .fifo_ready(acq_wr_ready),
        .acq_ready(acq_ready), .acq_trig(chan_trig),
        .fifo_valid(acq_wr_valid), .fifo_data(acq_wr_data),
        .state(cac_state)
    );

    sync_fifo #(.ENTRY_T(trig_rec_t)) trig_fifo (   // timestamp, number, type
        .ttc_clk(ttc_clk), .rst_n(rst_n),
        .wr_valid(trig_wr_valid), .wr_data(trig_wr_data), .wr_ready(trig_wr_ready),
        .rd_valid(trig_rd_valid), .rd_data(trig_rd_data), .rd_ready(trig_rd_ready),
        .almost_full(trig_fifo_full)
    );

    sync_fifo #(.ENTRY_T(acq_rec_t)) acq_fifo (     // number, type, empty flag
        .ttc_clk(ttc_clk), .rst_n(rst_n),
        .wr_valid(acq_wr_valid), .wr_data(acq_wr_data), .wr_ready(acq_wr_ready),
        .rd_valid(acq_rd_valid), .rd_data(acq_rd_data), .rd_ready(acq_rd_ready),
        .almost_full(acq_fifo_full)
    );

    trigger_processor trigger_processor (
        .ttc_clk(ttc_clk), .rst_n(rst_n),
        .trig_valid(trig_rd_valid), .trig_data(trig_rd_data), .trig_ready(trig_rd_ready),
        .acq_valid(acq_rd_valid), .acq_data(acq_rd_data), .acq_ready(acq_rd_ready),
        .readout_ready(readout_ready), .readout_done(readout_done),
        .initiate_readout(initiate_readout), .send_empty_event(send_empty_event),
        .ttc_info(ttc_info), .state(tp_state),
        .error_trig_num(error_trig_num), .error_trig_type(error_trig_type)
    );

endmodule

`default_nettype wire

/* hdl/ttc_trigger_receiver.sv */
// TTC trigger receiver with acceptance, numbering, timestamping and rate error
`timescale 1ns/100ps
`default_nettype none

module ttc_trigger_receiver
    import trig_types_pkg::*;
(
    input  wire        ttc_clk,
    input  wire        rst_n,
    input  wire        trigger,               // TTC trigger pulse
    input  wire trig_type_t trig_type,
    input  wire chan_mask_t chan_en,          // sampled at acceptance
    input  wire delay_t     trig_delay,       // sampled at acceptance
    input  wire        reset_trig_num,        // from TTC channel B
    input  wire        reset_trig_timestamp,  // from TTC channel B
    input  wire        acq_ready,             // acquisition controller idle
    input  wire        fifo_ready,            // trigger FIFO has room
    output logic       acq_trigger,           // one-cycle request to the controller
    output acq_rec_t   acq_rec,
    output chan_mask_t acq_chan_en,
    output delay_t     acq_delay,
    output logic       fifo_valid,
    output trig_rec_t  fifo_data,
    output trig_num_t  trig_num,              // number of the latest accepted trigger
    output timestamp_t trig_timestamp,        // timestamp of the latest accepted trigger
    output logic       error_trig_rate        // sticky, trigger refused
);

    logic       accept;
    logic       num_rst_pend;  // next accepted number restarts at 1
    timestamp_t ts_cnt;        // free-running cycle counter
    trig_num_t  next_num;

    // a request still in flight to the controller blocks a second one
    assign accept   = trigger && acq_ready && fifo_ready && !acq_trigger;
    assign next_num = (num_rst_pend || reset_trig_num) ? trig_num_t'(1) : trig_num + 1'b1;

    // ------------------------------------------------------------
    // counters
    // ------------------------------------------------------------
    always_ff @(posedge ttc_clk or negedge rst_n) begin
        if (!rst_n) begin
            ts_cnt       <= '0;
            num_rst_pend <= 1'b0;
        end else begin
            ts_cnt <= reset_trig_timestamp ? '0 : ts_cnt + 1'b1;
            if (accept)
                num_rst_pend <= 1'b0;      // consumed by this trigger
            else if (reset_trig_num)
                num_rst_pend <= 1'b1;
        end
    end

    // ------------------------------------------------------------
    // acceptance and handshakes
    // ------------------------------------------------------------
    always_ff @(posedge ttc_clk or negedge rst_n) begin
        if (!rst_n) begin
            acq_trigger     <= 1'b0;
            fifo_valid      <= 1'b0;
            trig_num        <= '0;
            trig_timestamp  <= '0;
            error_trig_rate <= 1'b0;
        end else begin
            acq_trigger <= accept;
            if (accept) begin
                fifo_valid     <= 1'b1;
                trig_num       <= next_num;
                trig_timestamp <= ts_cnt;
            end else if (fifo_ready) begin
                fifo_valid <= 1'b0;        // beat transferred
            end
            if (trigger && !accept)
                error_trig_rate <= 1'b1;   // too fast or FIFO near full
        end
    end

    // record payload, captured with the accepting edge
    always_ff @(posedge ttc_clk) begin
        if (accept) begin
            fifo_data.timestamp <= ts_cnt;
            fifo_data.trig_num  <= next_num;
            fifo_data.trig_type <= trig_type;
            acq_rec.trig_num    <= next_num;
            acq_rec.trig_type   <= trig_type;
            acq_rec.empty       <= (chan_en == '0);
            acq_chan_en         <= chan_en;
            acq_delay           <= trig_delay;
        end
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+hdl
hdl/trig_types_pkg.sv
hdl/trig_fsm_pkg.sv
hdl/sync_fifo.sv
hdl/ttc_trigger_receiver.sv
hdl/channel_acq_controller.sv
hdl/trigger_processor.sv
hdl/trigger_top.sv
dv/trigger_checker.sv
dv/trigger_tb.sv
